//--- hbm_interface.f
+incdir+source
source/hbm_pkg.sv
source/hbm_param_loader.sv
source/hbm_read_dispatch.sv
source/distram_fifo.sv
source/bank_pair_merge.sv
source/hbm_interface.sv
testbench/tb_clock_gen.sv
testbench/tb_hbm_interface.sv

//--- source/bank_pair_merge.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module bank_pair_merge
    import hbm_pkg::*;
(
    input  logic                            hbm_clk,
    input  logic                            hbm_rstn,

    input  logic                            start_i,
    input  logic [31:0]                     beats_per_ch_i,

    // both channel fifos
    input  logic [1:0]                      fifo_empty_i,
    input  logic [1:0]                      fifo_valid_i,
    input  logic [1:0][`HBM_BEAT_WIDTH-1:0] fifo_dout_i,
    output logic [1:0]                      fifo_re_o,

    // merged output, almost-full flow control
    input  logic                            line_afull_i,
    output logic                            line_valid_o,
    output hbm_line_t                       line_o,
    output logic                            done_o
);

    logic                            re_q;        // joint read strobe
    logic                            stage_valid;
    logic [1:0][`HBM_BEAT_WIDTH-1:0] stage_data;
    logic                            run_active;  // waiting on lines
    logic [31:0]                     line_cnt;

    assign fifo_re_o = {re_q, re_q};  // fifos always move together

    //////////////////////////////////////////////////////////////////////
    // read issue, one in flight so empty is never stale
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            re_q <= 1'b0;
        end else begin
            re_q <= ~fifo_empty_i[0] & ~fifo_empty_i[1] & ~line_afull_i & ~re_q;
        end
    end

    // fifo out -> stage -> line, two edges
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            stage_valid  <= 1'b0;
            line_valid_o <= 1'b0;
        end else begin
            stage_valid  <= &fifo_valid_i;
            line_valid_o <= stage_valid;
        end
    end

    always_ff @(posedge hbm_clk) begin
        stage_data <= fifo_dout_i;
        line_o     <= {stage_data[1], stage_data[0]};  // ch1 on top
    end

    //////////////////////////////////////////////////////////////////////
    // line count and done
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            run_active <= 1'b0;
            line_cnt   <= 32'd0;
            done_o     <= 1'b0;
        end else if (start_i) begin
            run_active <= (beats_per_ch_i != 32'd0);
            line_cnt   <= 32'd0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;  // pulse
            if (line_valid_o && run_active) begin
                line_cnt <= line_cnt + 32'd1;
                if (line_cnt + 32'd1 == beats_per_ch_i) begin
                    done_o     <= 1'b1;
                    run_active <= 1'b0;
                end
            end
        end
    end

endmodule

//--- source/distram_fifo.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module distram_fifo #(
    parameter int FIFO_WIDTH      = 256,
    parameter int FIFO_DEPTH_BITS = 6
) (
    input  logic                  hbm_clk,
    input  logic                  hbm_rstn,

    // write side
    input  logic                  we_i,
    input  logic [FIFO_WIDTH-1:0] din_i,
    output logic                  almostfull_o,

    // read side
    input  logic                  re_i,
    output logic [FIFO_WIDTH-1:0] dout_o,
    output logic                  valid_o,
    output logic                  empty_o
);

    localparam logic [FIFO_DEPTH_BITS:0] FULL_LEVEL  = 1 << FIFO_DEPTH_BITS;
    localparam logic [FIFO_DEPTH_BITS:0] AFULL_LEVEL =
        (1 << FIFO_DEPTH_BITS) - `HBM_FIFO_AFULL_MARGIN;

    logic [FIFO_WIDTH-1:0]      mem [1 << FIFO_DEPTH_BITS];  // lut ram
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;   // occupancy, one bit wider
    logic                       push;
    logic                       pop;

    assign empty_o      = (count == '0);
    assign almostfull_o = (count >= AFULL_LEVEL);
    assign push         = we_i & (count != FULL_LEVEL);  // drop on full
    assign pop          = re_i & ~empty_o;

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps naturally
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage and registered read port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (push) mem[wr_ptr] <= din_i;
        if (pop)  dout_o      <= mem[rd_ptr];
    end

    // flags each popped word
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= pop;
        end
    end

endmodule

//--- source/hbm_defines.svh
`ifndef HBM_DEFINES_SVH
`define HBM_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// stream widths
//////////////////////////////////////////////////////////////////////

`define HBM_PARAM_WIDTH        512  // one parameter word from host
`define HBM_BEAT_WIDTH         256  // hbm read data beat
`define HBM_LINE_WIDTH         512  // two beats side by side

//////////////////////////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////////////////////////

`define HBM_FIFO_DEPTH_BITS    6    // 64 entries per channel
`define HBM_FIFO_AFULL_MARGIN  8    // free slots left at almost-full

// b data is 4 bytes per sample
`define HBM_B_LEN_SHIFT        2

`endif

//--- source/hbm_interface.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module hbm_interface
    import hbm_pkg::*;
(
    input  logic            hbm_clk,
    input  logic            hbm_rstn,

    // parameter word stream
    input  logic            param_valid_i,
    input  hbm_param_word_u param_word_i,
    output logic            param_ready_o,
    output hbm_run_cfg_t    cfg_o,

    // one bank pair of hbm read data
    input  logic [1:0]      rd_valid_i,
    input  hbm_rd_beat_t    rd_beat_i [2],
    output logic [1:0]      rd_ready_o,

    // merged lines
    input  logic            line_afull_i,
    output logic            line_valid_o,
    output hbm_line_t       line_o,
    output logic            done_o
);

    logic                            start;
    logic [31:0]                     beats_per_ch;
    logic [1:0]                      fifo_we;
    logic [1:0][`HBM_BEAT_WIDTH-1:0] fifo_din;
    logic [1:0]                      fifo_afull;
    logic [1:0]                      fifo_re;
    logic [1:0][`HBM_BEAT_WIDTH-1:0] fifo_dout;
    logic [1:0]                      fifo_valid;
    logic [1:0]                      fifo_empty;

    hbm_param_loader u_loader (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .param_valid_i  (param_valid_i),
        .param_word_i   (param_word_i),
        .param_ready_o  (param_ready_o),
        .cfg_o          (cfg_o),
        .beats_per_ch_o (beats_per_ch),
        .start_o        (start)
    );

    //////////////////////////////////////////////////////////////////////
    // per channel: dispatch into its own fifo
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < 2; k++) begin : g_ch
        hbm_read_dispatch u_dispatch (
            .hbm_clk        (hbm_clk),
            .hbm_rstn       (hbm_rstn),
            .start_i        (start),
            .beats_per_ch_i (beats_per_ch),
            .rd_valid_i     (rd_valid_i[k]),
            .rd_beat_i      (rd_beat_i[k]),
            .rd_ready_o     (rd_ready_o[k]),
            .fifo_afull_i   (fifo_afull[k]),
            .fifo_we_o      (fifo_we[k]),
            .fifo_din_o     (fifo_din[k])
        );

        distram_fifo #(
            .FIFO_WIDTH      (`HBM_BEAT_WIDTH),
            .FIFO_DEPTH_BITS (`HBM_FIFO_DEPTH_BITS)
        ) u_fifo (
            .hbm_clk      (hbm_clk),
            .hbm_rstn     (hbm_rstn),
            .we_i         (fifo_we[k]),
            .din_i        (fifo_din[k]),
            .almostfull_o (fifo_afull[k]),  // throttles the dispatch
            .re_i         (fifo_re[k]),
            .dout_o       (fifo_dout[k]),
            .valid_o      (fifo_valid[k]),
            .empty_o      (fifo_empty[k])
        );
    end

    bank_pair_merge u_merge (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .start_i        (start),
        .beats_per_ch_i (beats_per_ch),
        .fifo_empty_i   (fifo_empty),
        .fifo_valid_i   (fifo_valid),
        .fifo_dout_i    (fifo_dout),
        .fifo_re_o      (fifo_re),
        .line_afull_i   (line_afull_i),
        .line_valid_o   (line_valid_o),
        .line_o         (line_o),
        .done_o         (done_o)
    );

endmodule

//--- source/hbm_param_loader.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module hbm_param_loader
    import hbm_pkg::*;
(
    input  logic            hbm_clk,
    input  logic            hbm_rstn,

    input  logic            param_valid_i,
    input  hbm_param_word_u param_word_i,
    output logic            param_ready_o,

    output hbm_run_cfg_t    cfg_o,
    output logic [31:0]     beats_per_ch_o,
    output logic            start_o
);

    hbm_param_word_u word_q;   // captured word
    logic            acc_q;    // word captured last edge
    logic            accept;

    assign accept = param_valid_i & param_ready_o;

    // ready sits high once out of reset
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            param_ready_o <= 1'b0;
        end else begin
            param_ready_o <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1: capture raw word
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (accept) begin
            word_q.raw <= param_word_i.raw;
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            acc_q   <= 1'b0;
            start_o <= 1'b0;
        end else begin
            acc_q   <= accept;
            start_o <= acc_q;  // single cycle, fields valid alongside
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: decode fields, stage 3: b length follows
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            cfg_o          <= '0;
            beats_per_ch_o <= 32'd0;
        end else begin
            if (acc_q) begin
                cfg_o.addr_model        <= word_q.fields.addr_model;
                cfg_o.mini_batch_size   <= word_q.fields.mini_batch_size;
                cfg_o.step_size         <= word_q.fields.step_size;
                cfg_o.number_of_epochs  <= word_q.fields.number_of_epochs;
                cfg_o.dimension         <= word_q.fields.dimension;
                cfg_o.number_of_samples <= word_q.fields.number_of_samples;
                cfg_o.number_of_bits    <= word_q.fields.number_of_bits;
                beats_per_ch_o          <= word_q.fields.data_a_length >> 1; // split over 2 ch
            end
            // trails the sample count by one edge
            cfg_o.data_b_length <= cfg_o.number_of_samples << `HBM_B_LEN_SHIFT;
        end
    end

endmodule

//--- source/hbm_pkg.sv
`include "hbm_defines.svh"

package hbm_pkg;

    //////////////////////////////////////////////////////////////////////
    // parameter word, msb first
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] spare;              // 511:480, unused
        logic [31:0] channel_choice;     // 479:448
        logic [31:0] array_length;       // 447:416
        logic [31:0] data_a_length;      // 415:384
        logic [31:0] number_of_bits;     // 383:352
        logic [31:0] number_of_samples;  // 351:320
        logic [31:0] dimension;          // 319:288
        logic [31:0] number_of_epochs;   // 287:256
        logic [31:0] step_size;          // 255:224
        logic [31:0] mini_batch_size;    // 223:192
        logic [63:0] addr_model;         // 191:128
        logic [63:0] addr_b;             // 127:64
        logic [63:0] addr_a;             // 63:0
    } hbm_param_fields_t;

    // same 512 bits, seen raw or split into fields
    typedef union packed {
        logic [`HBM_PARAM_WIDTH-1:0] raw;
        hbm_param_fields_t           fields;
    } hbm_param_word_u;

    //////////////////////////////////////////////////////////////////////
    // latched run settings
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [63:0] addr_model;
        logic [31:0] mini_batch_size;
        logic [31:0] step_size;
        logic [31:0] number_of_epochs;
        logic [31:0] dimension;
        logic [31:0] number_of_samples;
        logic [31:0] number_of_bits;
        logic [31:0] data_b_length;      // derived, samples * 4
    } hbm_run_cfg_t;

    // one beat off an hbm read data channel
    typedef struct packed {
        logic [`HBM_BEAT_WIDTH-1:0] data;
        logic                       last;
    } hbm_rd_beat_t;

    typedef logic [`HBM_LINE_WIDTH-1:0] hbm_line_t;  // ch1 high, ch0 low

endpackage

//--- source/hbm_read_dispatch.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module hbm_read_dispatch
    import hbm_pkg::*;
(
    input  logic                       hbm_clk,
    input  logic                       hbm_rstn,

    // run control
    input  logic                       start_i,
    input  logic [31:0]                beats_per_ch_i,

    // hbm read data channel
    input  logic                       rd_valid_i,
    input  hbm_rd_beat_t               rd_beat_i,
    output logic                       rd_ready_o,

    // towards the channel fifo
    input  logic                       fifo_afull_i,
    output logic                       fifo_we_o,
    output logic [`HBM_BEAT_WIDTH-1:0] fifo_din_o
);

    logic        active;    // inside a run, beats still owed
    logic [31:0] beat_cnt;  // beats taken this run
    logic        accept;

    //////////////////////////////////////////////////////////////////////
    // acceptance
    //////////////////////////////////////////////////////////////////////

    // hold off while the fifo is nearly full
    assign rd_ready_o = active & ~fifo_afull_i;
    assign accept     = rd_valid_i & rd_ready_o;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            active   <= 1'b0;
            beat_cnt <= 32'd0;
        end else if (start_i) begin
            // zero length run never opens
            active   <= (beats_per_ch_i != 32'd0);
            beat_cnt <= 32'd0;
        end else if (accept) begin
            beat_cnt <= beat_cnt + 32'd1;
            if (beat_cnt + 32'd1 == beats_per_ch_i) begin
                active <= 1'b0;  // limit reached
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // one register stage before the fifo
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            fifo_we_o <= 1'b0;
        end else begin
            fifo_we_o <= accept;
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (accept) begin
            fifo_din_o <= rd_beat_i.data;  // last flag not kept, count ends the run
        end
    end

    // at most two beats in flight past a rising almost-full,
    // well inside the fifo margin

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic hbm_clk_o,
    output logic hbm_rstn_o
);

    localparam int HALF_PERIOD  = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        hbm_clk_o = 1'b0;
        forever #HALF_PERIOD hbm_clk_o = ~hbm_clk_o;
    end

    // reset low from time zero, released on an edge
    initial begin
        hbm_rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge hbm_clk_o);
        hbm_rstn_o <= 1'b1;
    end

endmodule

//--- testbench/tb_hbm_interface.sv
`timescale 1ns/1ns
`include "hbm_defines.svh"

module tb_hbm_interface
    import hbm_pkg::*;
();

    logic                       hbm_clk;
    logic                       hbm_rstn;
    logic                       param_valid;
    hbm_param_word_u            param_word;
    logic                       param_ready;
    hbm_run_cfg_t               cfg;
    logic [1:0]                 rd_valid;
    hbm_rd_beat_t               rd_beat [2];
    logic [1:0]                 rd_ready;
    logic                       line_afull;
    logic                       line_valid;
    hbm_line_t                  line_out;
    logic                       done;

    logic [`HBM_BEAT_WIDTH-1:0] sent0_q [$];  // ch0 beats in accept order
    logic [`HBM_BEAT_WIDTH-1:0] sent1_q [$];  // ch1 beats
    int acc [2];                              // beats taken per channel
    int lines;
    int done_cnt;
    int afull_lines;                          // lines since afull rose
    int cur_l;                                // beat limit of current run
    logic mon_en;
    logic check_idle;
    int rst_edges;
    int afull_hold;                           // cycles left on an afull pulse
    string test_name;
    int errors;
    int test_err_start;
    int tests_run;
    int tests_failed;

    tb_clock_gen u_clk_gen (.hbm_clk_o(hbm_clk), .hbm_rstn_o(hbm_rstn));

    hbm_interface u_dut (
        .hbm_clk       (hbm_clk),
        .hbm_rstn      (hbm_rstn),
        .param_valid_i (param_valid),
        .param_word_i  (param_word),
        .param_ready_o (param_ready),
        .cfg_o         (cfg),
        .rd_valid_i    (rd_valid),
        .rd_beat_i     (rd_beat),
        .rd_ready_o    (rd_ready),
        .line_afull_i  (line_afull),
        .line_valid_o  (line_valid),
        .line_o        (line_out),
        .done_o        (done)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string what, input logic [511:0] exp,
                                   input logic [511:0] act);
        $display("mismatch in %s: %s expected %0h actual %0h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout in %s: %s", test_name, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`HBM_BEAT_WIDTH-1:0] random_beat();
        logic [`HBM_BEAT_WIDTH-1:0] b;
        for (int i = 0; i < `HBM_BEAT_WIDTH / 32; i++) b[i*32 +: 32] = $urandom;
        return b;
    endfunction

    function automatic hbm_param_word_u random_word(input int unsigned a_len);
        hbm_param_word_u w;
        for (int i = 0; i < 16; i++) w.raw[i*32 +: 32] = $urandom;
        w.raw[415:384] = a_len;  // data_a_length slot
        return w;
    endfunction

    // call right after a rising edge
    task automatic send_param(input hbm_param_word_u w);
        int cyc;
        bit taken;
        param_valid <= 1'b1;
        param_word  <= w;
        taken = 1'b0;
        cyc   = 0;
        while (!taken && cyc < 50) begin
            @(posedge hbm_clk);
            taken = param_ready;  // valid was high at this edge
            cyc++;
        end
        if (!taken) abort_on_timeout("parameter word never accepted");
        param_valid <= 1'b0;
    endtask

    task automatic drive_cycle(input bit use_afull);
        for (int k = 0; k < 2; k++) begin
            if (!rd_valid[k] || rd_ready[k]) begin  // slot free or beat taken now
                if ($urandom_range(99) < ((k == 0) ? 70 : 35)) begin  // skewed
                    rd_valid[k]     <= 1'b1;
                    rd_beat[k].data <= random_beat();
                    rd_beat[k].last <= 1'b0;
                end else begin
                    rd_valid[k] <= 1'b0;
                end
            end
        end
        if (!use_afull) begin
            line_afull <= 1'b0;
        end else if (afull_hold > 0) begin
            afull_hold--;
            if (afull_hold == 0) line_afull <= 1'b0;
        end else if ($urandom_range(99) < 4) begin
            line_afull <= 1'b1;  // pulse of 5 to 25 cycles
            afull_hold = 5 + $urandom_range(20);
        end
    endtask

    task automatic check_field(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act == exp) else report_mismatch(what, exp, act);
    endtask

    task automatic check_decode();
        hbm_param_word_u w;
        logic [31:0]     exp_b;
        @(posedge hbm_clk);
        w = random_word(0);  // zero length keeps the read path idle
        send_param(w);
        repeat (3) @(posedge hbm_clk);  // fields at n+1 and b length at n+2
        exp_b = w.raw[351:320] * 4;
        check_field("addr_model", w.raw[191:128], cfg.addr_model);
        check_field("mini_batch_size", w.raw[223:192], cfg.mini_batch_size);
        check_field("step_size", w.raw[255:224], cfg.step_size);
        check_field("number_of_epochs", w.raw[287:256], cfg.number_of_epochs);
        check_field("dimension", w.raw[319:288], cfg.dimension);
        check_field("number_of_samples", w.raw[351:320], cfg.number_of_samples);
        check_field("number_of_bits", w.raw[383:352], cfg.number_of_bits);
        check_field("data_b_length", exp_b, cfg.data_b_length);
    endtask

    task automatic run_stream(input string name, input int l, input bit use_afull);
        int cyc;
        begin_test(name);
        @(posedge hbm_clk);
        sent0_q.delete();
        sent1_q.delete();
        acc[0]      <= 0;
        acc[1]      <= 0;
        lines       <= 0;
        done_cnt    <= 0;
        afull_lines <= 0;
        cur_l       <= l;
        mon_en      <= 1'b1;
        send_param(random_word(2 * l));  // split over both channels
        cyc = 0;
        while (!(done_cnt == 1 && lines == l) && cyc < 400 * l + 2000) begin
            @(posedge hbm_clk);
            drive_cycle(use_afull);
            cyc++;
        end
        if (!(done_cnt == 1 && lines == l)) abort_on_timeout("run never reached done");
        repeat (20) begin
            @(posedge hbm_clk);
            drive_cycle(1'b0);  // beats still offered past the limit
        end
        @(posedge hbm_clk);
        rd_valid   <= 2'b00;
        line_afull <= 1'b0;
        mon_en     <= 1'b0;
        @(posedge hbm_clk);
        assert (acc[0] == l) else report_mismatch("channel 0 beats", l, acc[0]);
        assert (acc[1] == l) else report_mismatch("channel 1 beats", l, acc[1]);
        assert (done_cnt == 1) else report_mismatch("done pulses", 1, done_cnt);
        assert (sent0_q.size() == 0 && sent1_q.size() == 0)
            else report_error("beats accepted but never merged");
        end_test();
    endtask

    //////////////////////////////////////////////////////////////////////
    // monitor sampling pre-edge values
    //////////////////////////////////////////////////////////////////////

    always @(posedge hbm_clk) begin
        logic [`HBM_LINE_WIDTH-1:0] exp_line;
        if (check_idle && rst_edges > 0) begin  // first reset edge still x
            assert (rd_ready === 2'b00)
                else report_mismatch("rd_ready_o around reset", 0, rd_ready);
            assert (line_valid === 1'b0)
                else report_mismatch("line_valid_o around reset", 0, line_valid);
            assert (done === 1'b0)
                else report_mismatch("done_o around reset", 0, done);
            if (!hbm_rstn) begin
                assert (param_ready === 1'b0)
                    else report_mismatch("param_ready_o in reset", 0, param_ready);
            end
        end
        if (!hbm_rstn) rst_edges++;
        if (!mon_en && line_valid === 1'b1) report_error("line_valid_o high outside a run");
        if (mon_en) begin
            for (int k = 0; k < 2; k++) begin
                if (acc[k] >= cur_l) begin
                    assert (!rd_ready[k])
                        else report_error($sformatf("channel %0d ready past its limit", k));
                end
                if (rd_valid[k] && rd_ready[k]) begin
                    assert (acc[k] < cur_l)
                        else report_error($sformatf("channel %0d took too many beats", k));
                    if (k == 0) sent0_q.push_back(rd_beat[0].data);
                    else        sent1_q.push_back(rd_beat[1].data);
                    acc[k] <= acc[k] + 1;
                end
            end
            if (line_valid) begin
                if (sent0_q.size() == 0 || sent1_q.size() == 0) begin
                    report_error("line came out with no beat pair behind it");
                end else begin
                    exp_line = {sent1_q.pop_front(), sent0_q.pop_front()};  // ch1 high
                    assert (line_out == exp_line) else report_mismatch("line", exp_line, line_out);
                end
                assert (lines < cur_l) else report_error("more lines than the beat limit");
                lines <= lines + 1;
            end
            if (line_afull) begin
                assert (afull_lines + line_valid <= 3)
                    else report_error("more than 3 lines after line_afull_i rose");
                afull_lines <= afull_lines + line_valid;
            end else begin
                afull_lines <= 0;
            end
            if (done) begin
                assert (done_cnt == 0) else report_error("done_o pulsed more than once");
                assert (lines == cur_l) else report_mismatch("lines at done", cur_l, lines);
                done_cnt <= done_cnt + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int cyc;
        void'($urandom(32'h2c0c_51da));
        param_valid = 1'b0;
        param_word  = '0;
        rd_valid    = 2'b00;
        rd_beat[0]  = '0;
        rd_beat[1]  = '0;
        line_afull  = 1'b0;
        mon_en      = 1'b0;
        check_idle  = 1'b1;
        rst_edges   = 0;
        afull_hold  = 0;
        cur_l       = 0;
        acc[0]      = 0;
        acc[1]      = 0;
        lines       = 0;
        done_cnt    = 0;
        afull_lines = 0;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;

        begin_test("reset");
        cyc = 0;
        while (!hbm_rstn && cyc < 64) begin
            @(posedge hbm_clk);
            cyc++;
        end
        if (!hbm_rstn) abort_on_timeout("hbm_rstn never released");
        repeat (4) @(posedge hbm_clk);  // quiet right after release too
        check_idle <= 1'b0;
        end_test();

        begin_test("param_decode");
        repeat (2) check_decode();
        end_test();

        run_stream("merged_stream", 24, 1'b0);
        run_stream("backpressure", 120, 1'b1);  // deeper than the fifo
        run_stream("restart", 40, 1'b1);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
